/* verilog/icache_pkg.sv */
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address and data widths
  ////////////////////////////////////////////////////////////////////////////

  // physical byte address
  localparam int unsigned addr_w = 32;

  // one fetch word
  localparam int unsigned word_w = 32;

  // refill granule, one full line per return
  localparam int unsigned line_words = 4;
  localparam int unsigned line_w     = line_words * word_w;

  // byte offset inside a line
  localparam int unsigned offset_w = 4;

  // top half of the address space is the I/O region, never cached
  localparam int unsigned nc_bit = 31;

  ////////////////////////////////////////////////////////////////////////////
  // controller states
  ////////////////////////////////////////////////////////////////////////////

  // IDLE   accepts fetches
  // READ   tag compare, hit return or refill request
  // MISS   wait for the refill line
  // FLUSH  walk all sets and clear valid bits
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    MISS  = 2'd2,
    FLUSH = 2'd3
  } ctrl_state_e;

endpackage

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  input  logic                          req_i,
  input  logic [icache_pkg::addr_w-1:0] addr_i,
  input  logic                          hit_i,
  input  logic                          flush_done_i,
  input  logic                          mem_ack_i,
  input  logic                          mem_rtrn_vld_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic                          busy_o,
  output logic                          miss_o,
  output logic                          lookup_o,
  output logic [icache_pkg::addr_w-1:0] req_addr_o,
  output logic                          fill_o,
  output logic                          flush_en_o,
  output logic                          repl_capture_o,
  output logic                          mem_req_o,
  output logic [icache_pkg::addr_w-1:0] mem_addr_o,
  output logic                          mem_nc_o
);

  localparam int unsigned aw = icache_pkg::addr_w;
  localparam int unsigned ow = icache_pkg::offset_w;

  icache_pkg::ctrl_state_e state_d, state_q;
  logic                    cache_en_d, cache_en_q;
  logic                    flush_d, flush_q;
  logic                    lookup_q;
  logic [aw-1:0]           req_addr_q;
  logic                    req_nc;

  // I/O region or disabled cache both take the uncached path
  assign req_nc     = req_addr_q[icache_pkg::nc_bit] | ~cache_en_q;
  assign mem_nc_o   = req_nc;
  // word address for uncached, line address otherwise
  assign mem_addr_o = req_nc ? {req_addr_q[aw-1:2], 2'b00} :
                               {req_addr_q[aw-1:ow], {ow{1'b0}}};
  assign req_addr_o = req_addr_q;

  assign lookup_o = req_i & ready_o;
  assign busy_o   = (state_q != icache_pkg::IDLE);
  // first READ cycle that turns into a refill request
  assign repl_capture_o = lookup_q & mem_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disabling takes effect at once, enabling only through a flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    miss_o     = 1'b0;
    fill_o     = 1'b0;
    flush_en_o = 1'b0;
    mem_req_o  = 1'b0;
    unique case (state_q)
      icache_pkg::IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            state_d = icache_pkg::READ;
          end
        end
      end
      icache_pkg::READ: begin
        if (hit_i && !req_nc) begin
          valid_o = 1'b1;
          state_d = icache_pkg::IDLE;
          // overlap the next lookup with this return
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              state_d = icache_pkg::READ;
            end
          end
        end else begin
          // hold the request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~req_nc;
            state_d = icache_pkg::MISS;
          end
        end
      end
      icache_pkg::MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          fill_o  = ~req_nc;
          state_d = icache_pkg::IDLE;
        end
      end
      icache_pkg::FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done_i) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= icache_pkg::IDLE;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      lookup_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      lookup_q   <= lookup_o;
    end
  end

  // request address, loaded on every accepted fetch
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      req_addr_q <= addr_i;
    end
  end

endmodule

/* verilog/icache_flush_cnt.sv */
`timescale 1ns/1ps

module icache_flush_cnt #(
  parameter int unsigned num_sets = 64
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_en_i,
  output logic [$clog2(num_sets)-1:0] flush_idx_o,
  output logic                        flush_done_o
);

  localparam int unsigned idx_w = $clog2(num_sets);

  logic [idx_w-1:0] cnt_q;
  logic             last_set;

  assign last_set     = (cnt_q == idx_w'(num_sets - 1));
  assign flush_done_o = flush_en_i & last_set;
  assign flush_idx_o  = cnt_q;

  // one set per cycle, back to zero after the last one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (flush_en_i) begin
      cnt_q <= last_set ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

/* verilog/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array #(
  parameter int unsigned num_ways = 4,
  parameter int unsigned num_sets = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          lookup_i,
  input  logic [icache_pkg::addr_w-1:0] addr_i,
  input  logic [icache_pkg::addr_w-1:0] req_addr_i,
  input  logic                          fill_i,
  input  logic [num_ways-1:0]           repl_way_oh_i,
  input  logic                          flush_en_i,
  input  logic [$clog2(num_sets)-1:0]   flush_idx_i,
  output logic [num_ways-1:0]           hit_oh_o,
  output logic [num_ways-1:0]           valid_vec_o
);

  localparam int unsigned ow    = icache_pkg::offset_w;
  localparam int unsigned idx_w = $clog2(num_sets);
  localparam int unsigned tag_w = icache_pkg::addr_w - ow - idx_w;

  logic [tag_w-1:0]    tag_mem [num_sets][num_ways];
  logic [num_ways-1:0] vld_q [num_sets];
  logic [tag_w-1:0]    tag_rd_q [num_ways];
  logic [num_ways-1:0] vld_rd_q;
  logic [idx_w-1:0]    rd_idx;
  logic [idx_w-1:0]    wr_idx;
  logic [tag_w-1:0]    req_tag;

  // lookups index with the incoming address, fills with the held one
  assign rd_idx  = addr_i[ow +: idx_w];
  assign wr_idx  = req_addr_i[ow +: idx_w];
  assign req_tag = req_addr_i[icache_pkg::addr_w-1 -: tag_w];

  // tag storage, all ways read together
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < num_ways; w++) begin
      if (lookup_i) begin
        tag_rd_q[w] <= tag_mem[rd_idx][w];
      end
      if (fill_i && repl_way_oh_i[w]) begin
        tag_mem[wr_idx][w] <= req_tag;
      end
    end
  end

  // valid bits, flush wins over fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < num_sets; s++) begin
        vld_q[s] <= '0;
      end
      vld_rd_q <= '0;
    end else begin
      if (lookup_i) begin
        vld_rd_q <= vld_q[rd_idx];
      end
      if (flush_en_i) begin
        vld_q[flush_idx_i] <= '0;
      end else if (fill_i) begin
        vld_q[wr_idx] <= vld_q[wr_idx] | repl_way_oh_i;
      end
    end
  end

  // compare against the registered request tag
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_oh_o[w] = vld_rd_q[w] & (tag_rd_q[w] == req_tag);
    end
  end

  assign valid_vec_o = vld_rd_q;

endmodule

/* verilog/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array #(
  parameter int unsigned num_ways = 4,
  parameter int unsigned num_sets = 64
) (
  input  logic                          clk_i,
  input  logic                          lookup_i,
  input  logic [icache_pkg::addr_w-1:0] addr_i,
  input  logic [icache_pkg::addr_w-1:0] req_addr_i,
  input  logic                          fill_i,
  input  logic [num_ways-1:0]           repl_way_oh_i,
  input  logic [num_ways-1:0]           hit_oh_i,
  input  logic                          mem_rtrn_vld_i,
  input  logic [icache_pkg::line_w-1:0] mem_rtrn_data_i,
  output logic [icache_pkg::word_w-1:0] data_o
);

  localparam int unsigned ow    = icache_pkg::offset_w;
  localparam int unsigned lw    = icache_pkg::line_w;
  localparam int unsigned idx_w = $clog2(num_sets);

  logic [lw-1:0]    line_mem [num_sets][num_ways];
  logic [lw-1:0]    line_rd_q [num_ways];
  logic [lw-1:0]    hit_line;
  logic [lw-1:0]    sel_line;
  logic [ow-3:0]    word_off;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < num_ways; w++) begin
      if (lookup_i) begin
        line_rd_q[w] <= line_mem[addr_i[ow +: idx_w]][w];
      end
      if (fill_i && repl_way_oh_i[w]) begin
        line_mem[req_addr_i[ow +: idx_w]][w] <= mem_rtrn_data_i;
      end
    end
  end

  // and-or mux, hit vector is one-hot or zero
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit_line = hit_line | (line_rd_q[w] & {lw{hit_oh_i[w]}});
    end
  end

  // refill line bypasses the arrays in the return cycle
  assign sel_line = mem_rtrn_vld_i ? mem_rtrn_data_i : hit_line;
  assign word_off = req_addr_i[ow-1:2];
  assign data_o   = sel_line[word_off*icache_pkg::word_w +: icache_pkg::word_w];

endmodule

/* verilog/icache_repl.sv */
`timescale 1ns/1ps

module icache_repl #(
  parameter int unsigned num_ways = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [num_ways-1:0] valid_vec_i,
  input  logic                repl_capture_i,
  input  logic                fill_i,
  output logic [num_ways-1:0] repl_way_oh_o
);

  localparam int unsigned way_w = $clog2(num_ways);

  logic [7:0]          lfsr_q;
  logic [way_w-1:0]    inv_way;
  logic [way_w-1:0]    way_sel;
  logic                all_valid;
  logic                all_valid_q;
  logic [num_ways-1:0] repl_way_oh_q;

  // lowest invalid way, scan from the top down
  always_comb begin
    inv_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        inv_way = way_w'(w);
      end
    end
  end

  assign all_valid = &valid_vec_i;
  assign way_sel   = all_valid ? lfsr_q[way_w-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q        <= 8'hff;
      all_valid_q   <= 1'b0;
      repl_way_oh_q <= '0;
    end else begin
      if (repl_capture_i) begin
        repl_way_oh_q <= num_ways'(1) << way_sel;
        all_valid_q   <= all_valid;
      end
      // x^8 + x^6 + x^5 + x^4 + 1, advance only on random refills
      if (fill_i && all_valid_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  assign repl_way_oh_o = repl_way_oh_q;

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter int unsigned num_ways = 4,
  parameter int unsigned num_sets = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  input  logic                          req_i,
  input  logic [icache_pkg::addr_w-1:0] addr_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic [icache_pkg::word_w-1:0] data_o,
  output logic                          busy_o,
  output logic                          miss_o,
  output logic                          mem_req_o,
  output logic [icache_pkg::addr_w-1:0] mem_addr_o,
  output logic                          mem_nc_o,
  input  logic                          mem_ack_i,
  input  logic                          mem_rtrn_vld_i,
  input  logic [icache_pkg::line_w-1:0] mem_rtrn_data_i
);

  localparam int unsigned idx_w = $clog2(num_sets);

  logic                          lookup;
  logic [icache_pkg::addr_w-1:0] req_addr;
  logic                          fill;
  logic                          flush_en;
  logic                          repl_capture;
  logic [num_ways-1:0]           hit_oh;
  logic [num_ways-1:0]           valid_vec;
  logic [idx_w-1:0]              flush_idx;
  logic                          flush_done;
  logic [num_ways-1:0]           repl_way_oh;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .hit_i          (|hit_oh),
    .flush_done_i   (flush_done),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .busy_o         (busy_o),
    .miss_o         (miss_o),
    .lookup_o       (lookup),
    .req_addr_o     (req_addr),
    .fill_o         (fill),
    .flush_en_o     (flush_en),
    .repl_capture_o (repl_capture),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_nc_o       (mem_nc_o)
  );

  icache_flush_cnt #(.num_sets(num_sets)) u_flush_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_en_i   (flush_en),
    .flush_idx_o  (flush_idx),
    .flush_done_o (flush_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // arrays and replacement
  ////////////////////////////////////////////////////////////////////////////

  icache_tag_array #(.num_ways(num_ways), .num_sets(num_sets)) u_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .addr_i        (addr_i),
    .req_addr_i    (req_addr),
    .fill_i        (fill),
    .repl_way_oh_i (repl_way_oh),
    .flush_en_i    (flush_en),
    .flush_idx_i   (flush_idx),
    .hit_oh_o      (hit_oh),
    .valid_vec_o   (valid_vec)
  );

  icache_data_array #(.num_ways(num_ways), .num_sets(num_sets)) u_data_array (
    .clk_i           (clk_i),
    .lookup_i        (lookup),
    .addr_i          (addr_i),
    .req_addr_i      (req_addr),
    .fill_i          (fill),
    .repl_way_oh_i   (repl_way_oh),
    .hit_oh_i        (hit_oh),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .data_o          (data_o)
  );

  icache_repl #(.num_ways(num_ways)) u_repl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_vec_i    (valid_vec),
    .repl_capture_i (repl_capture),
    .fill_i         (fill),
    .repl_way_oh_o  (repl_way_oh)
  );

endmodule

/* tb/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

  localparam int unsigned num_ways = 4;
  localparam int unsigned num_sets = 64;
  // two flushes and a few dozen refills fit well inside this limit
  localparam int unsigned timeout_cycles = 4000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          en_i;
  logic                          flush_i;
  logic                          req_i;
  logic [icache_pkg::addr_w-1:0] addr_i;
  logic                          ready_o;
  logic                          valid_o;
  logic [icache_pkg::word_w-1:0] data_o;
  logic                          busy_o;
  logic                          miss_o;
  logic                          mem_req_o;
  logic [icache_pkg::addr_w-1:0] mem_addr_o;
  logic                          mem_nc_o;
  logic                          mem_ack_i;
  logic                          mem_rtrn_vld_i;
  logic [icache_pkg::line_w-1:0] mem_rtrn_data_i;

  int          errors = 0;
  int          miss_cnt = 0;
  logic [31:0] lcg_state = 32'h386e;
  logic [31:0] seen_addr;
  logic        seen_nc;

  icache_top #(.num_ways(num_ways), .num_sets(num_sets)) u_icache_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .busy_o          (busy_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // reference data and helpers
  ////////////////////////////////////////////////////////////////////////////

  // memory content is its own word address xor a fixed pattern
  function automatic logic [31:0] exp_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [127:0] mem_line(input logic [31:0] addr);
    logic [127:0] line;
    for (int k = 0; k < 4; k++) begin
      line[k*32 +: 32] = exp_word({addr[31:4], 4'h0} + 32'(k * 4));
    end
    return line;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // ack two cycles after the request and return the line three cycles later
  always begin
    @(negedge clk_i);
    if (rst_ni && mem_req_o) begin
      seen_addr = mem_addr_o;
      seen_nc   = mem_nc_o;
      repeat (2) @(posedge clk_i);
      #1;
      mem_ack_i = 1'b1;
      @(posedge clk_i);
      #1;
      mem_ack_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #1;
      mem_rtrn_vld_i  = 1'b1;
      mem_rtrn_data_i = mem_line(seen_addr);
      @(posedge clk_i);
      #1;
      mem_rtrn_vld_i = 1'b0;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && miss_o) begin
      miss_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch and flush tasks
  ////////////////////////////////////////////////////////////////////////////

  // one fetch that reports whether it reached memory
  task automatic fetch(input logic [31:0] addr, output bit went_mem);
    int          miss_before;
    bit          exp_nc;
    logic [31:0] exp_maddr;
    exp_nc      = addr[icache_pkg::nc_bit] | ~en_i;
    exp_maddr   = exp_nc ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0};
    miss_before = miss_cnt;
    @(posedge clk_i);
    #1;
    req_i  = 1'b1;
    addr_i = addr;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    @(negedge clk_i);
    // a hit returns here and a miss raises its request here
    assert (valid_o || mem_req_o)
      else note_error($sformatf("no response one cycle after accepting %h", addr));
    went_mem = !valid_o;
    if (!went_mem) begin
      assert (!mem_req_o && !miss_o)
        else note_error($sformatf("hit on address %h also went to memory", addr));
    end
    while (!valid_o) begin
      @(negedge clk_i);
    end
    assert (data_o === exp_word(addr))
      else note_error($sformatf("** Error: data_o = %h, expected %h at address %h",
                                data_o, exp_word(addr), addr));
    if (went_mem) begin
      assert (seen_addr === exp_maddr)
        else note_error($sformatf("** Error: mem_addr_o = %h, expected %h",
                                  seen_addr, exp_maddr));
      assert (seen_nc === exp_nc)
        else note_error($sformatf("** Error: mem_nc_o = %h, expected %h", seen_nc, exp_nc));
      assert (miss_cnt - miss_before == (exp_nc ? 0 : 1))
        else note_error($sformatf("miss_o pulsed %0d times for address %h",
                                  miss_cnt - miss_before, addr));
    end
  endtask

  // flush starts in the cycle after the trigger and walks every set
  task automatic run_flush();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(negedge clk_i);
    assert (busy_o) else note_error("busy_o did not rise for the flush");
    while (busy_o) begin
      cycles++;
      @(negedge clk_i);
    end
    assert (cycles == num_sets)
      else note_error($sformatf("** Error: flush length = %h, expected %h", cycles, num_sets));
  endtask

  // requests every cycle to the two cached lines of set 0x23
  task automatic hit_burst(input int n);
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] prev;
    @(posedge clk_i);
    #1;
    for (int i = 0; i <= n; i++) begin
      if (i < n) begin
        rnd    = lcg_next();
        a      = {16'h0, rnd[31] ? 8'h12 : 8'h56, 4'h3, rnd[30:29], 2'b00};
        req_i  = 1'b1;
        addr_i = a;
      end else begin
        req_i = 1'b0;
      end
      @(negedge clk_i);
      if (i < n) begin
        assert (ready_o) else note_error($sformatf("burst request %0d not accepted", i));
      end
      if (i > 0) begin
        assert (valid_o) else note_error($sformatf("burst word %0d came late", i - 1));
        assert (data_o === exp_word(prev))
          else note_error($sformatf("** Error: data_o = %h, expected %h at address %h",
                                    data_o, exp_word(prev), prev));
      end
      assert (!mem_req_o) else note_error("burst hit went to memory");
      prev = a;
      @(posedge clk_i);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_enable_flush();
    bit m;
    @(posedge clk_i);
    #1;
    en_i = 1'b1;
    run_flush();
    fetch(32'h0000_1234, m);
    assert (m) else note_error("first fetch after enable did not miss");
  endtask

  task automatic test_hit_latency();
    bit m;
    fetch(32'h0000_1234, m);
    assert (!m) else note_error("repeated fetch of 00001234 missed");
    fetch(32'h0000_1230, m);
    assert (!m) else note_error("fetch of 00001230 in a cached line missed");
    fetch(32'h0000_123c, m);
    assert (!m) else note_error("fetch of 0000123c in a cached line missed");
    // second line of the same set for the burst
    fetch(32'h0000_5634, m);
    assert (m) else note_error("first fetch of 00005634 did not miss");
    hit_burst(12);
  endtask

  task automatic test_noncacheable();
    bit m;
    fetch(32'h8000_0104, m);
    assert (m) else note_error("I/O fetch of 80000104 did not go to memory");
    fetch(32'h8000_0104, m);
    assert (m) else note_error("repeated I/O fetch of 80000104 was served from the cache");
    fetch(32'h8000_0108, m);
    assert (m) else note_error("I/O fetch of 80000108 did not go to memory");
  endtask

  task automatic test_flush();
    bit m;
    fetch(32'h0000_1234, m);
    assert (!m) else note_error("cached address missed before the flush");
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    run_flush();
    fetch(32'h0000_1234, m);
    assert (m) else note_error("address still hit after the flush");
  endtask

  // five tags in set 0x04 is one more than the ways
  task automatic test_replacement();
    bit m;
    int refills;
    refills = 0;
    for (int k = 0; k < 5; k++) begin
      fetch(32'h0000_2040 + 32'(k * 32'h400) + 32'(k % 4 * 4), m);
      assert (m) else note_error($sformatf("first fetch of tag %0d did not miss", k));
    end
    for (int k = 0; k < 5; k++) begin
      fetch(32'h0000_2040 + 32'(k * 32'h400) + 32'(k % 4 * 4), m);
      refills += m;
    end
    assert (refills > 0) else note_error("five tags in one set all hit on the second pass");
  endtask

  task automatic test_disabled();
    bit m;
    @(posedge clk_i);
    #1;
    en_i = 1'b0;
    fetch(32'h0000_1234, m);
    assert (m) else note_error("fetch with the cache disabled did not go to memory");
    fetch(32'h0000_1234, m);
    assert (m) else note_error("second fetch with the cache disabled was served locally");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    en_i            = 1'b0;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_enable_flush();
    test_hit_latency();
    test_noncacheable();
    test_flush();
    test_replacement();
    test_disabled();
    $display("tb_icache finished with %0d errors", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("timeout, tests still running after %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* list.f */
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_flush_cnt.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_repl.sv
verilog/icache_top.sv
tb/tb_icache.sv
